/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes, rv32i base set only
    localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register alu
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate alu
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // ecall and ebreak

    // funct3 for arithmetic and logic
    localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;     // imm[11:0]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } rv_s_fmt_t;

    typedef struct packed {
        logic       imm_12;   // sign bit
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_fmt_t;

    typedef struct packed {
        logic       imm_20;   // sign bit
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    // one instruction word, six ways to read it
    typedef union packed {
        rv_r_fmt_t r;
        rv_i_fmt_t i;
        rv_s_fmt_t s;
        rv_b_fmt_t b;
        rv_u_fmt_t u;
        rv_j_fmt_t j;
    } rv_instr_u;

endpackage

/* common/exec_cfg_pkg.sv */
package exec_cfg_pkg;

    localparam int XLEN   = 32; // datapath width
    localparam int REG_AW = 5;  // register index width, x0..x31

    // operation classes seen by the evaluators and writeback
    localparam logic [2:0] OPC_CLS_ALU    = 3'd0; // op and op-imm
    localparam logic [2:0] OPC_CLS_UPPER  = 3'd1; // lui, auipc
    localparam logic [2:0] OPC_CLS_JUMP   = 3'd2; // jal, jalr
    localparam logic [2:0] OPC_CLS_BRANCH = 3'd3; // conditional branches
    localparam logic [2:0] OPC_CLS_HALT   = 3'd4; // ecall / ebreak
    localparam logic [2:0] OPC_CLS_NONE   = 3'd5; // unknown opcode, no effect

endpackage

/* common/operand_if.sv */
interface operand_if;
    import exec_cfg_pkg::*;

    logic [XLEN-1:0]   rs1_val;  // register file read port a
    logic [XLEN-1:0]   rs2_val;  // register file read port b
    logic [XLEN-1:0]   imm;      // sign extended, format already resolved
    logic [XLEN-1:0]   pc;       // pc of the instruction in the stage
    logic [2:0]        funct3;
    logic              alt;      // sub / sra, also lui within upper, jalr within jump
    logic              use_imm;  // alu operand b from imm
    logic [2:0]        op_cls;
    logic [REG_AW-1:0] rd_addr;

    modport src (
        output rs1_val, rs2_val, imm, pc, funct3, alt, use_imm, op_cls, rd_addr
    );

    modport sink (
        input rs1_val, rs2_val, imm, pc, funct3, alt, use_imm, op_cls, rd_addr
    );

endinterface

/* common/writeback_if.sv */
interface writeback_if;
    import exec_cfg_pkg::*;

    logic              advance;  // instruction leaves, next one loads
    logic              rd_we;    // qualified with advance already
    logic [REG_AW-1:0] rd_addr;
    logic [XLEN-1:0]   rd_data;

    modport ctrl (
        output advance, rd_we, rd_addr, rd_data
    );

    modport regs (
        input advance, rd_we, rd_addr, rd_data
    );

endinterface

/* exec/operand_fetch.sv */
module operand_fetch #(
    parameter int NUM_REGS = 32
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [exec_cfg_pkg::XLEN-1:0]    instr_i,
    input  logic [exec_cfg_pkg::XLEN-1:0]    pc_i,
    writeback_if.regs                        wb,
    operand_if.src                           ops,
    input  logic [exec_cfg_pkg::REG_AW-1:0]  dbg_addr_i,
    output logic [exec_cfg_pkg::XLEN-1:0]    dbg_data_o
);
    import exec_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS); // 5 for rv32i, 4 for rv32e

    rv_instr_u       instr_q;               // instruction in the stage
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] rf_q [NUM_REGS];       // x0 never written

    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_b;
    logic [XLEN-1:0]   imm_u;
    logic [XLEN-1:0]   imm_j;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q <= NOP_INSTR;
            pc_q    <= '0;
        end else if (wb.advance) begin       // held under stall or back-pressure
            instr_q <= instr_i;
            pc_q    <= pc_i;
        end
    end

    // single write port, x0 and out of range indices dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                rf_q[k] <= '0;
            end
        end else if (wb.advance && wb.rd_we && wb.rd_addr != '0 && wb.rd_addr < NUM_REGS) begin
            rf_q[wb.rd_addr[IDX_W-1:0]] <= wb.rd_data;
        end
    end

    assign rs1 = instr_q.r.rs1;
    assign rs2 = instr_q.r.rs2;

    // read ports, indices past NUM_REGS read as zero
    assign ops.rs1_val = (rs1 < NUM_REGS) ? rf_q[rs1[IDX_W-1:0]] : '0;
    assign ops.rs2_val = (rs2 < NUM_REGS) ? rf_q[rs2[IDX_W-1:0]] : '0;
    assign dbg_data_o  = (dbg_addr_i < NUM_REGS) ? rf_q[dbg_addr_i[IDX_W-1:0]] : '0;

    // immediates per format view
    assign imm_i = {{(XLEN-12){instr_q.i.imm[11]}}, instr_q.i.imm};
    assign imm_b = {{(XLEN-13){instr_q.b.imm_12}}, instr_q.b.imm_12, instr_q.b.imm_11,
                    instr_q.b.imm_10_5, instr_q.b.imm_4_1, 1'b0};
    assign imm_u = {instr_q.u.imm_31_12, 12'b0};            // low 12 bits zero
    assign imm_j = {{(XLEN-21){instr_q.j.imm_20}}, instr_q.j.imm_20, instr_q.j.imm_19_12,
                    instr_q.j.imm_11, instr_q.j.imm_10_1, 1'b0};

    assign ops.pc      = pc_q;
    assign ops.funct3  = instr_q.r.funct3;
    assign ops.rd_addr = instr_q.r.rd;

    // opcode to class, immediate select, variant bit
    always_comb begin
        ops.op_cls  = OPC_CLS_NONE;
        ops.use_imm = 1'b0;
        ops.alt     = 1'b0;
        ops.imm     = '0;
        case (instr_q.r.opcode)
            OPC_OP: begin
                ops.op_cls = OPC_CLS_ALU;
                ops.alt    = instr_q.r.funct7[5];       // sub, sra
            end
            OPC_OP_IMM: begin
                ops.op_cls  = OPC_CLS_ALU;
                ops.use_imm = 1'b1;
                ops.imm     = imm_i;
                ops.alt     = (instr_q.i.funct3 == F3_SR) && instr_q.i.imm[10]; // srai only
            end
            OPC_LUI: begin
                ops.op_cls = OPC_CLS_UPPER;
                ops.imm    = imm_u;
                ops.alt    = 1'b1;                      // no pc added
            end
            OPC_AUIPC: begin
                ops.op_cls = OPC_CLS_UPPER;
                ops.imm    = imm_u;
            end
            OPC_JAL: begin
                ops.op_cls = OPC_CLS_JUMP;
                ops.imm    = imm_j;
            end
            OPC_JALR: begin
                ops.op_cls = OPC_CLS_JUMP;
                ops.imm    = imm_i;
                ops.alt    = 1'b1;                      // target from rs1
            end
            OPC_BRANCH: begin
                ops.op_cls = OPC_CLS_BRANCH;
                ops.imm    = imm_b;
            end
            OPC_SYSTEM: ops.op_cls = OPC_CLS_HALT;      // ecall and ebreak alike
            default: ops.op_cls = OPC_CLS_NONE;
        endcase
    end

endmodule

/* exec/alu.sv */
module alu (
    operand_if.sink                        ops,
    output logic [exec_cfg_pkg::XLEN-1:0]  alu_result_o
);
    import exec_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;     // rs2[4:0] or imm[4:0]
    logic            lt_s;
    logic            lt_u;

    assign op_a  = ops.rs1_val;
    assign op_b  = ops.use_imm ? ops.imm : ops.rs2_val;
    assign shamt = op_b[4:0];

    // compares shared by slt/slti and sltu/sltiu
    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;  // imm already sign extended, compared unsigned

    always_comb begin
        case (ops.funct3)
            F3_ADD: begin
                if (ops.alt) begin
                    alu_result_o = op_a - op_b;         // sub
                end else begin
                    alu_result_o = op_a + op_b;         // add, addi
                end
            end
            F3_SLL: alu_result_o = op_a << shamt;
            F3_SLT: alu_result_o = {{(XLEN-1){1'b0}}, lt_s};
            F3_SLTU: alu_result_o = {{(XLEN-1){1'b0}}, lt_u};
            F3_XOR: alu_result_o = op_a ^ op_b;
            F3_SR: begin
                if (ops.alt) begin
                    alu_result_o = $signed(op_a) >>> shamt; // sign fill
                end else begin
                    alu_result_o = op_a >> shamt;
                end
            end
            F3_OR: alu_result_o = op_a | op_b;
            F3_AND: alu_result_o = op_a & op_b;
            default: alu_result_o = '0;
        endcase
    end

endmodule

/* exec/branch_unit.sv */
module branch_unit (
    operand_if.sink                        ops,
    output logic                           taken_o,
    output logic [exec_cfg_pkg::XLEN-1:0]  target_o
);
    import exec_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            cond;      // branch condition per funct3
    logic [XLEN-1:0] pc_rel;    // branches and jal
    logic [XLEN-1:0] reg_rel;   // jalr

    assign eq   = ops.rs1_val == ops.rs2_val;
    assign lt_s = $signed(ops.rs1_val) < $signed(ops.rs2_val);
    assign lt_u = ops.rs1_val < ops.rs2_val;

    always_comb begin
        case (ops.funct3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt_s;
            F3_BGE:  cond = !lt_s;
            F3_BLTU: cond = lt_u;
            F3_BGEU: cond = !lt_u;  // rs1 >= rs2 unsigned
            default: cond = 1'b0;   // 010, 011 not branches
        endcase
    end

    assign pc_rel  = ops.pc + ops.imm;
    assign reg_rel = ops.rs1_val + ops.imm;

    // jumps always taken, branches on condition
    assign taken_o = (ops.op_cls == OPC_CLS_JUMP) ||
                     (ops.op_cls == OPC_CLS_BRANCH && cond);

    assign target_o = (ops.op_cls == OPC_CLS_JUMP && ops.alt)
                      ? {reg_rel[XLEN-1:1], 1'b0}     // jalr clears bit 0
                      : pc_rel;

endmodule

/* exec/writeback_ctrl.sv */
module writeback_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           valid_i,
    operand_if.sink                        ops,
    input  logic [exec_cfg_pkg::XLEN-1:0]  alu_result_i,
    input  logic                           taken_i,
    input  logic [exec_cfg_pkg::XLEN-1:0]  target_i,
    writeback_if.ctrl                      wb,
    output logic                           accept_o,
    output logic                           jump_o,
    output logic [exec_cfg_pkg::XLEN-1:0]  jump_pc_o,
    output logic                           halted_o
);
    import exec_cfg_pkg::*;

    logic jump_pending_q;   // jump strobe already given for this instruction
    logic halted_q;         // sticky until reset
    logic is_halt;
    logic writes_rd;

    assign is_halt = ops.op_cls == OPC_CLS_HALT;

    // strobe once per taken transfer, then let it leave
    assign jump_o    = taken_i && !jump_pending_q;
    assign jump_pc_o = target_i;

    // ecall blocks from the cycle it sits in the stage
    assign accept_o = valid_i && !jump_o && !is_halt && !halted_q;
    assign halted_o = halted_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_pending_q <= 1'b0;
            halted_q       <= 1'b0;
        end else begin
            if (jump_o) begin
                jump_pending_q <= 1'b1;
            end else if (accept_o) begin
                jump_pending_q <= 1'b0;     // cleared when the jump retires
            end
            if (is_halt) begin
                halted_q <= 1'b1;
            end
        end
    end

    assign writes_rd = (ops.op_cls == OPC_CLS_ALU) ||
                       (ops.op_cls == OPC_CLS_UPPER) ||
                       (ops.op_cls == OPC_CLS_JUMP);

    assign wb.advance = accept_o;
    assign wb.rd_we   = accept_o && writes_rd;  // write at the leaving edge
    assign wb.rd_addr = ops.rd_addr;

    // destination value by class
    always_comb begin
        case (ops.op_cls)
            OPC_CLS_ALU: wb.rd_data = alu_result_i;
            OPC_CLS_UPPER: begin
                if (ops.alt) begin
                    wb.rd_data = ops.imm;               // lui
                end else begin
                    wb.rd_data = ops.pc + ops.imm;      // auipc
                end
            end
            OPC_CLS_JUMP: wb.rd_data = ops.pc + XLEN'(4); // link
            default: wb.rd_data = '0;                   // no write
        endcase
    end

endmodule

/* source/exec_stage.sv */
module exec_stage #(
    parameter int NUM_REGS = 32     // 16 for an rv32e register file
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [exec_cfg_pkg::XLEN-1:0]    instr_i,
    input  logic [exec_cfg_pkg::XLEN-1:0]    pc_i,
    input  logic                             valid_i,
    input  logic [exec_cfg_pkg::REG_AW-1:0]  dbg_addr_i,
    output logic                             accept_o,
    output logic                             jump_o,
    output logic [exec_cfg_pkg::XLEN-1:0]    jump_pc_o,
    output logic                             halted_o,
    output logic [exec_cfg_pkg::XLEN-1:0]    dbg_data_o
);
    import exec_cfg_pkg::*;

    operand_if   ops_if ();         // decoded operands, level only
    writeback_if wb_if ();          // write and advance back to fetch

    logic [XLEN-1:0] alu_result;
    logic            br_taken;
    logic [XLEN-1:0] br_target;

    operand_fetch #(
        .NUM_REGS (NUM_REGS)
    ) u_operand_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .wb         (wb_if.regs),
        .ops        (ops_if.src),
        .dbg_addr_i (dbg_addr_i),
        .dbg_data_o (dbg_data_o)
    );

    alu u_alu (
        .ops          (ops_if.sink),
        .alu_result_o (alu_result)
    );

    branch_unit u_branch_unit (
        .ops      (ops_if.sink),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

    writeback_ctrl u_writeback_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .ops          (ops_if.sink),
        .alu_result_i (alu_result),
        .taken_i      (br_taken),
        .target_i     (br_target),
        .wb           (wb_if.ctrl),
        .accept_o     (accept_o),
        .jump_o       (jump_o),
        .jump_pc_o    (jump_pc_o),
        .halted_o     (halted_o)
    );

endmodule

/* testbench/exec_stage_asserts.sv */
module exec_stage_asserts (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             accept_i,
    input logic                             jump_i,
    input logic                             halted_i,
    input logic [exec_cfg_pkg::REG_AW-1:0]  dbg_addr_i,
    input logic [exec_cfg_pkg::XLEN-1:0]    dbg_data_i
);
    import exec_cfg_pkg::*;

    // jump strobe lasts one cycle only
    a_jump_single: assert property (@(posedge clk) disable iff (!rst_n)
        jump_i |=> !jump_i)
        else $error("jump_o high on two consecutive cycles");

    a_jump_stall: assert property (@(posedge clk) disable iff (!rst_n)
        jump_i |-> !accept_i)
        else $error("accept_o high while jump_o is high");

    // halt is sticky and blocks the stage
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted_i |=> halted_i)
        else $error("halted_o dropped without reset");

    a_halt_block: assert property (@(posedge clk) disable iff (!rst_n)
        halted_i |-> !accept_i)
        else $error("accept_o high after halt");

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (dbg_addr_i == '0) |-> (dbg_data_i == '0))
        else $error("x0 reads nonzero on debug port");

endmodule

bind exec_stage exec_stage_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept_i   (accept_o),
    .jump_i     (jump_o),
    .halted_i   (halted_o),
    .dbg_addr_i (dbg_addr_i),
    .dbg_data_i (dbg_data_o)
);

/* testbench/exec_stage_tb.sv */
module exec_stage_tb;
    import exec_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam int MAX_CYCLES = 2000;   // tests need about 200

    logic              clk;
    logic              rst_n;
    logic [XLEN-1:0]   instr_i;
    logic [XLEN-1:0]   pc_i;
    logic              valid_i;
    logic [REG_AW-1:0] dbg_addr_i;
    logic              accept_o;
    logic              jump_o;
    logic [XLEN-1:0]   jump_pc_o;
    logic              halted_o;
    logic [XLEN-1:0]   dbg_data_o;

    logic [31:0]     lfsr;              // fibonacci lfsr with taps 32 22 2 1
    logic [XLEN-1:0] model_rf [32];     // expected register contents
    logic [XLEN-1:0] cur_pc;            // pc given with the next instruction
    int              cycle_cnt = 0;

    exec_stage #(.NUM_REGS(32)) dut0 (
        .clk(clk), .rst_n(rst_n), .instr_i(instr_i), .pc_i(pc_i), .valid_i(valid_i),
        .dbg_addr_i(dbg_addr_i), .accept_o(accept_o), .jump_o(jump_o),
        .jump_pc_o(jump_pc_o), .halted_o(halted_o), .dbg_data_o(dbg_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timeout");
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};        // one step per bit
        end
        return r;
    endfunction

    // instruction assembly
    function automatic logic [31:0] r_type_word(logic [6:0] f7, logic [4:0] rs2,
                                                logic [4:0] rs1, logic [2:0] f3,
                                                logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type_word(logic [11:0] imm, logic [4:0] rs1,
                                                logic [2:0] f3, logic [4:0] rd,
                                                logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type_word(logic [12:0] off, logic [4:0] rs2,
                                                logic [4:0] rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type_word(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // rv32i reference semantics
    function automatic logic signed_lt(logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);     // sign bits decide first
    endfunction

    function automatic logic [XLEN-1:0] alu_model(logic [2:0] f3, logic alt,
                                                  logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        logic [XLEN-1:0] res;
        logic [4:0]      sh;
        sh = b[4:0];
        case (f3)
            F3_ADD:  res = alt ? a - b : a + b;
            F3_SLL:  res = a << sh;
            F3_SLT:  res = {31'd0, signed_lt(a, b)};
            F3_SLTU: res = {31'd0, a < b};
            F3_XOR:  res = a ^ b;
            F3_SR:   res = (alt && a[31]) ? ((a >> sh) | ~(32'hffff_ffff >> sh)) : (a >> sh);
            F3_OR:   res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic branch_model(logic [2:0] f3, logic [XLEN-1:0] a,
                                          logic [XLEN-1:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return signed_lt(a, b);
            F3_BGE:  return !signed_lt(a, b);
            F3_BLTU: return a < b;
            default: return !(a < b);               // bgeu
        endcase
    endfunction

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // called and returns at 5 units after a rising edge
    task automatic send_instr(input logic [31:0] word);
        instr_i = word;
        pc_i    = cur_pc;
        valid_i = 1'b1;
        @(negedge clk);
        while (!accept_o) begin
            @(posedge clk);
            #5;
            @(negedge clk);
        end
        @(posedge clk);
        #5;
        valid_i = 1'b0;                      // stage holds it now
        cur_pc  = cur_pc + 32'd4;
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [XLEN-1:0] val);
        if (rd != 5'd0) model_rf[rd] = val;
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [XLEN-1:0] val);
        logic [19:0] hi;
        hi = val[31:12] + {19'd0, val[11]};  // addi below sign extends
        send_instr({hi, rd, OPC_LUI});
        send_instr(i_type_word(val[11:0], rd, F3_ADD, rd, OPC_OP_IMM));
        write_reg(rd, val);
    endtask

    task automatic compare_regs();
        for (int k = 0; k < 32; k++) begin
            dbg_addr_i = k[4:0];
            @(negedge clk);
            check_word($sformatf("dbg_data_o x%0d", k), dbg_data_o, model_rf[k[4:0]]);
            @(posedge clk);
            #5;
        end
    endtask

    // transfer in the stage with a nop queued behind
    task automatic verify_transfer(input logic taken, input logic [XLEN-1:0] target);
        if (taken) cur_pc = target;
        instr_i = NOP_INSTR;
        pc_i    = cur_pc;
        valid_i = 1'b1;
        @(negedge clk);
        check_bit("jump_o", jump_o, taken);
        check_bit("accept_o", accept_o, !taken);
        if (taken) begin
            check_word("jump_pc_o", jump_pc_o, target);
            @(posedge clk);
            #5;
            @(negedge clk);
            check_bit("jump_o", jump_o, 1'b0);      // single cycle stall
            check_bit("accept_o", accept_o, 1'b1);
        end
        @(posedge clk);
        #5;
        valid_i = 1'b0;
        cur_pc  = cur_pc + 32'd4;
    endtask

    task automatic reset_test();
        @(negedge clk);
        check_bit("accept_o", accept_o, 1'b0);
        check_bit("jump_o", jump_o, 1'b0);
        check_bit("halted_o", halted_o, 1'b0);
        @(posedge clk);
        #5;
        valid_i = 1'b1;
        @(negedge clk);
        check_bit("accept_o", accept_o, 1'b1);     // follows valid_i
        @(posedge clk);
        #5;
        valid_i = 1'b0;
        compare_regs();
    endtask

    task automatic alu_test();
        logic [31:0] tmp;
        logic [11:0] imm;
        load_reg(5'd1, rand_bits(32));
        load_reg(5'd2, rand_bits(32));
        for (int f = 0; f < 8; f++) begin
            send_instr(r_type_word(7'd0, 5'd2, 5'd1, f[2:0], 5'(10 + f)));
            write_reg(5'(10 + f), alu_model(f[2:0], 1'b0, model_rf[1], model_rf[2]));
            if (f == 1 || f == 5) begin
                tmp = rand_bits(5);
                imm = {7'd0, tmp[4:0]};      // shift amount only
            end else begin
                tmp = rand_bits(12);
                imm = tmp[11:0];
            end
            send_instr(i_type_word(imm, 5'd1, f[2:0], 5'(20 + f), OPC_OP_IMM));
            write_reg(5'(20 + f), alu_model(f[2:0], 1'b0, model_rf[1], {{20{imm[11]}}, imm}));
        end
        send_instr(r_type_word(7'h20, 5'd2, 5'd1, F3_ADD, 5'd18));   // sub
        write_reg(5'd18, alu_model(F3_ADD, 1'b1, model_rf[1], model_rf[2]));
        send_instr(r_type_word(7'h20, 5'd2, 5'd1, F3_SR, 5'd19));    // sra
        write_reg(5'd19, alu_model(F3_SR, 1'b1, model_rf[1], model_rf[2]));
        tmp = rand_bits(5);
        send_instr(i_type_word({7'h20, tmp[4:0]}, 5'd1, F3_SR, 5'd28, OPC_OP_IMM)); // srai
        write_reg(5'd28, alu_model(F3_SR, 1'b1, model_rf[1], {27'd0, tmp[4:0]}));
        send_instr(r_type_word(7'd0, 5'd2, 5'd1, F3_ADD, 5'd0));     // x0 stays 0
        send_instr(NOP_INSTR);                                        // last result retires
        compare_regs();
    endtask

    task automatic upper_jump_test();
        logic [31:0]     tmp;
        logic [11:0]     imm;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] tgt;
        tmp = rand_bits(20);
        send_instr({tmp[19:0], 5'd7, OPC_LUI});
        write_reg(5'd7, {tmp[19:0], 12'd0});
        tmp = rand_bits(20);
        pc  = cur_pc;
        send_instr({tmp[19:0], 5'd8, OPC_AUIPC});
        write_reg(5'd8, {tmp[19:0], 12'd0} + pc);
        tmp = rand_bits(20);
        pc  = cur_pc;
        send_instr(j_type_word({tmp[19:0], 1'b0}, 5'd9));
        write_reg(5'd9, pc + 32'd4);
        verify_transfer(1'b1, pc + {{11{tmp[19]}}, tmp[19:0], 1'b0});
        tmp    = rand_bits(11);
        imm    = {tmp[10:0], ~model_rf[1][0]};  // odd sum so bit 0 gets cleared
        pc     = cur_pc;
        tgt    = model_rf[1] + {{20{imm[11]}}, imm};
        tgt[0] = 1'b0;
        send_instr(i_type_word(imm, 5'd1, 3'd0, 5'd3, OPC_JALR));
        write_reg(5'd3, pc + 32'd4);
        verify_transfer(1'b1, tgt);
    endtask

    task automatic branch_test();
        logic [31:0] tmp;
        logic [XLEN-1:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        taken;
        tmp = rand_bits(31);
        load_reg(5'd5, {1'b1, tmp[30:0]});         // signed and unsigned order differ
        tmp = rand_bits(31);
        load_reg(5'd6, {1'b0, tmp[30:0]});
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) continue;
            for (int p = 0; p < 3; p++) begin       // (x5,x6) (x6,x5) (x5,x5)
                rs1   = (p == 1) ? 5'd6 : 5'd5;
                rs2   = (p == 0) ? 5'd6 : 5'd5;
                tmp   = rand_bits(12);
                pc    = cur_pc;
                taken = branch_model(f[2:0], model_rf[rs1], model_rf[rs2]);
                send_instr(b_type_word({tmp[11:0], 1'b0}, rs2, rs1, f[2:0]));
                verify_transfer(taken, pc + {{19{tmp[11]}}, tmp[11:0], 1'b0});
            end
        end
    endtask

    task automatic halt_test();
        send_instr(i_type_word(12'd0, 5'd0, 3'd0, 5'd0, OPC_SYSTEM));   // ecall
        instr_i = NOP_INSTR;
        valid_i = 1'b1;                     // held high from here on
        @(negedge clk);
        check_bit("accept_o", accept_o, 1'b0);
        check_bit("halted_o", halted_o, 1'b0);
        repeat (3) begin
            @(posedge clk);
            #5;
            @(negedge clk);
            check_bit("halted_o", halted_o, 1'b1);
            check_bit("accept_o", accept_o, 1'b0);
        end
        @(posedge clk);
        #5;
        compare_regs();                     // nothing written after ecall
    endtask

    initial begin
        lfsr       = 32'h7599_29e9;
        rst_n      = 1'b0;
        instr_i    = NOP_INSTR;
        pc_i       = '0;
        valid_i    = 1'b0;
        dbg_addr_i = '0;
        cur_pc     = 32'h0040_0000;
        for (int k = 0; k < 32; k++) model_rf[k] = '0;
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;
        reset_test();
        alu_test();
        upper_jump_test();
        branch_test();
        halt_test();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* exec_stage.f */
common/rv_isa_pkg.sv
common/exec_cfg_pkg.sv
common/operand_if.sv
common/writeback_if.sv
exec/operand_fetch.sv
exec/alu.sv
exec/branch_unit.sv
exec/writeback_ctrl.sv
source/exec_stage.sv
testbench/exec_stage_asserts.sv
testbench/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f exec_stage.f --top-module exec_stage_tb

out=$(./obj_dir/Vexec_stage_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
